// ==== Makefile ====
# Verilator build and run for the 6502 execution slice

TOP = m6502_exec_tb

.PHONY: run lint clean

run:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)
	verilator --lint-only -f list.f --top-module m6502_exec

clean:
	rm -rf obj_dir sim.log

// ==== include/m6502_defs.svh ====
`ifndef M6502_DEFS_SVH
`define M6502_DEFS_SVH

// Datapath width of the core
`define M6502_DATA_W 8

// Status register after reset, only the unused bit set
`define M6502_P_RESET 8'h20

// Bit positions inside P
`define M6502_P_C 0
`define M6502_P_Z 1
`define M6502_P_U 5
`define M6502_P_V 6
`define M6502_P_N 7

`endif

// ==== list.f ====
+incdir+include
logic/m6502_pkg.sv
logic/m6502_alu.sv
logic/m6502_decode.sv
logic/m6502_regs.sv
logic/m6502_exec.sv
verif/m6502_exec_tb.sv

// ==== logic/m6502_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "m6502_defs.svh"

module m6502_alu
  import m6502_pkg::*;
(
  input  alu_op_t                   operation,
  input  logic [`M6502_DATA_W-1:0] op_a,
  input  logic [`M6502_DATA_W-1:0] op_b,
  input  logic                      carry_in,
  output logic [`M6502_DATA_W-1:0] result,
  output logic                      carry,
  output logic                      zero,
  output logic                      overflow
);

  localparam int MSB = `M6502_DATA_W - 1;
  localparam logic [`M6502_DATA_W:0] ONE_EXT = 1;

  // One bit wider than the data so the carry out is kept
  logic [`M6502_DATA_W:0] sum;
  logic [`M6502_DATA_W:0] cin_ext;

  assign cin_ext = {{`M6502_DATA_W{1'b0}}, carry_in};

  always_comb
  begin
    result   = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    sum      = '0;

    case (operation)
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_NOT: result = ~op_a;

      // Shifts fill the vacated bit from carry_in, rotates stay in the byte
      ALU_ASL:
      begin
        result = {op_a[MSB-1:0], carry_in};
        carry  = op_a[MSB];
      end
      ALU_ROL:
      begin
        result = {op_a[MSB-1:0], op_a[MSB]};
        carry  = op_a[MSB];
      end
      ALU_ASR:
      begin
        result = {carry_in, op_a[MSB:1]};
        carry  = op_a[0];
      end
      ALU_ROR:
      begin
        result = {op_a[0], op_a[MSB:1]};
        carry  = op_a[0];
      end

      ALU_ADD:
      begin
        sum      = {1'b0, op_a} + {1'b0, op_b} + cin_ext;
        result   = sum[MSB:0];
        carry    = sum[`M6502_DATA_W];
        overflow = (op_a[MSB] == op_b[MSB]) && (op_a[MSB] != result[MSB]);
      end
      ALU_INC:
      begin
        sum      = {1'b0, op_a} + ONE_EXT;
        result   = sum[MSB:0];
        carry    = sum[`M6502_DATA_W];
        overflow = !op_a[MSB] && result[MSB];
      end

      // Borrow is the inverted carry, as on the 6502
      ALU_SUB:
      begin
        sum      = {1'b0, op_a} + {1'b0, ~op_b} + cin_ext;
        result   = sum[MSB:0];
        carry    = sum[`M6502_DATA_W];
        overflow = (op_a[MSB] != op_b[MSB]) && (op_a[MSB] != result[MSB]);
      end
      ALU_DEC:
      begin
        result   = op_a - 1'b1;
        overflow = op_a[MSB] && !result[MSB];
      end

      // Compare is a subtract without borrow in, carry set when op_a >= op_b
      ALU_CMP:
      begin
        sum    = {1'b0, op_a} + {1'b0, ~op_b} + ONE_EXT;
        result = sum[MSB:0];
        carry  = sum[`M6502_DATA_W];
      end

      default:
      begin
        result = '0;
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== logic/m6502_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module m6502_decode
  import m6502_pkg::*;
(
  input  opcode_u    opcode,
  output alu_op_t    alu_op,
  output reg_sel_t   a_src,
  output logic       carry_src_use,
  output logic       b_is_operand,
  output reg_sel_t   dst,
  output logic [3:0] flag_mask,
  output logic       clc,
  output logic       sec
);

  // Flag mask bits from MSB down are N, Z, C, V
  localparam logic [3:0] MASK_NZ   = 4'b1100;
  localparam logic [3:0] MASK_NZC  = 4'b1110;
  localparam logic [3:0] MASK_NZCV = 4'b1111;

  logic imm_group;
  logic shift_group;

  // aaa=100 in the immediate column is STA, which has no immediate form
  assign imm_group   = (opcode.f.cc == 2'b01) && (opcode.f.bbb == 3'b010) &&
                       (opcode.f.aaa != 3'b100);
  // Upper half of this column is TXA, TAX, DEX, NOP and is matched elsewhere
  assign shift_group = (opcode.f.cc == 2'b10) && (opcode.f.bbb == 3'b010) &&
                       !opcode.f.aaa[2];

  always_comb
  begin
    alu_op        = ALU_NOP;
    a_src         = REG_NONE;
    carry_src_use = 1'b0;
    b_is_operand  = 1'b0;
    dst           = REG_NONE;
    flag_mask     = 4'b0000;
    clc           = 1'b0;
    sec           = 1'b0;

    case (opcode.raw)
      // INX, INY, DEX, DEY
      8'hE8, 8'hC8, 8'hCA, 8'h88:
      begin
        alu_op    = opcode.raw[7:6] == 2'b11 && opcode.raw[1] == 1'b0 ? ALU_INC : ALU_DEC;
        a_src     = (opcode.raw == 8'hE8 || opcode.raw == 8'hCA) ? REG_X : REG_Y;
        dst       = a_src;
        flag_mask = MASK_NZ;
      end
      // TAX and TAY pass A through OR with zero
      8'hAA, 8'hA8:
      begin
        alu_op    = ALU_OR;
        a_src     = REG_A;
        dst       = opcode.raw[1] ? REG_X : REG_Y;
        flag_mask = MASK_NZ;
      end
      8'h18: clc = 1'b1;
      8'h38: sec = 1'b1;
      default:
      begin
        if (imm_group)
        begin
          a_src        = REG_A;
          b_is_operand = 1'b1;
          dst          = REG_A;
          flag_mask    = MASK_NZ;
          case (opcode.f.aaa)
            3'b000: alu_op = ALU_OR;
            3'b001: alu_op = ALU_AND;
            3'b010: alu_op = ALU_XOR;
            3'b011:
            begin
              alu_op        = ALU_ADD;
              carry_src_use = 1'b1;
              flag_mask     = MASK_NZCV;
            end
            // LDA
            3'b101:
            begin
              alu_op = ALU_OR;
              a_src  = REG_NONE;
            end
            3'b110:
            begin
              alu_op    = ALU_CMP;
              dst       = REG_NONE;
              flag_mask = MASK_NZC;
            end
            // SBC
            default:
            begin
              alu_op        = ALU_SUB;
              carry_src_use = 1'b1;
              flag_mask     = MASK_NZCV;
            end
          endcase
        end
        else if (shift_group)
        begin
          // aaa[1] picks right shift, aaa[0] feeds C in for ROL/ROR
          alu_op        = opcode.f.aaa[1] ? ALU_ASR : ALU_ASL;
          carry_src_use = opcode.f.aaa[0];
          a_src         = REG_A;
          dst           = REG_A;
          flag_mask     = MASK_NZC;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/m6502_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "m6502_defs.svh"

module m6502_exec
  import m6502_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req,
  input  logic [`M6502_DATA_W-1:0] opcode,
  input  logic [`M6502_DATA_W-1:0] operand,
  output logic                      ack,
  output logic [`M6502_DATA_W-1:0] a_reg,
  output logic [`M6502_DATA_W-1:0] x_reg,
  output logic [`M6502_DATA_W-1:0] y_reg,
  output logic [`M6502_DATA_W-1:0] p_reg
);

  typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_DONE} state_t;

  state_t                    state;
  opcode_u                   opcode_q;
  logic [`M6502_DATA_W-1:0] operand_q;

  alu_op_t                   alu_op;
  reg_sel_t                  a_src;
  reg_sel_t                  dst;
  logic                      carry_src_use;
  logic                      b_is_operand;
  logic [3:0]                flag_mask;
  logic                      clc;
  logic                      sec;
  logic [`M6502_DATA_W-1:0] op_a;
  logic [`M6502_DATA_W-1:0] op_b;
  logic                      carry_in;
  logic [`M6502_DATA_W-1:0] result;
  logic                      carry;
  logic                      zero;
  logic                      overflow;
  logic                      commit;

  // Handshake FSM, ack held until req is seen low
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
      ack   <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (req)
            state <= ST_EXEC;
        ST_EXEC:
        begin
          ack   <= 1'b1;
          state <= ST_DONE;
        end
        ST_DONE:
          if (!req)
          begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Command is latched on the accepting edge
  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && req)
    begin
      opcode_q  <= opcode;
      operand_q <= operand;
    end
  end

  assign commit = (state == ST_EXEC);

  always_comb
  begin
    case (a_src)
      REG_A:   op_a = a_reg;
      REG_X:   op_a = x_reg;
      REG_Y:   op_a = y_reg;
      default: op_a = '0;
    endcase
  end

  assign op_b     = b_is_operand ? operand_q : '0;
  assign carry_in = carry_src_use & p_reg[`M6502_P_C];

  m6502_decode u_decode (
    .opcode        (opcode_q),
    .alu_op        (alu_op),
    .a_src         (a_src),
    .carry_src_use (carry_src_use),
    .b_is_operand  (b_is_operand),
    .dst           (dst),
    .flag_mask     (flag_mask),
    .clc           (clc),
    .sec           (sec)
  );

  m6502_alu u_alu (
    .operation (alu_op),
    .op_a      (op_a),
    .op_b      (op_b),
    .carry_in  (carry_in),
    .result    (result),
    .carry     (carry),
    .zero      (zero),
    .overflow  (overflow)
  );

  m6502_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .commit    (commit),
    .dst       (dst),
    .flag_mask (flag_mask),
    .clc       (clc),
    .sec       (sec),
    .result    (result),
    .carry     (carry),
    .zero      (zero),
    .overflow  (overflow),
    .a_reg     (a_reg),
    .x_reg     (x_reg),
    .y_reg     (y_reg),
    .p_reg     (p_reg)
  );

  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> req)
    else $error("ack raised without req");

  a_ack_held: assert property (@(posedge clk) disable iff (reset)
    ack && req |=> ack)
    else $error("ack dropped while req still high");

endmodule

`default_nettype wire

// ==== logic/m6502_pkg.sv ====
`default_nettype none

package m6502_pkg;

  // ALU operation codes
  typedef enum logic [7:0] {
    ALU_NOP = 8'h00,
    ALU_AND = 8'h01,
    ALU_OR  = 8'h02,
    ALU_XOR = 8'h03,
    ALU_NOT = 8'h04,
    ALU_ASL = 8'h11,
    ALU_ROL = 8'h12,
    ALU_ASR = 8'h13,
    ALU_ROR = 8'h14,
    ALU_ADD = 8'h21,
    ALU_INC = 8'h22,
    ALU_SUB = 8'h23,
    ALU_DEC = 8'h24,
    ALU_CMP = 8'h31
  } alu_op_t;

  // Opcode byte, seen either whole or as the aaa/bbb/cc fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [2:0] aaa;
      logic [2:0] bbb;
      logic [1:0] cc;
    } f;
  } opcode_u;

  // Register selector for ALU source and write destination
  typedef enum logic [1:0] {
    REG_NONE = 2'd0,
    REG_A    = 2'd1,
    REG_X    = 2'd2,
    REG_Y    = 2'd3
  } reg_sel_t;

endpackage

`default_nettype wire

// ==== logic/m6502_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "m6502_defs.svh"

module m6502_regs
  import m6502_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      commit,
  input  reg_sel_t                  dst,
  input  logic [3:0]                flag_mask,
  input  logic                      clc,
  input  logic                      sec,
  input  logic [`M6502_DATA_W-1:0] result,
  input  logic                      carry,
  input  logic                      zero,
  input  logic                      overflow,
  output logic [`M6502_DATA_W-1:0] a_reg,
  output logic [`M6502_DATA_W-1:0] x_reg,
  output logic [`M6502_DATA_W-1:0] y_reg,
  output logic [`M6502_DATA_W-1:0] p_reg
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      a_reg <= '0;
      x_reg <= '0;
      y_reg <= '0;
      p_reg <= `M6502_P_RESET;
    end
    else if (commit)
    begin
      case (dst)
        REG_A:   a_reg <= result;
        REG_X:   x_reg <= result;
        REG_Y:   y_reg <= result;
        default: ;
      endcase

      // Mask order is N, Z, C, V
      if (flag_mask[3])
        p_reg[`M6502_P_N] <= result[`M6502_DATA_W-1];
      if (flag_mask[2])
        p_reg[`M6502_P_Z] <= zero;
      if (flag_mask[1])
        p_reg[`M6502_P_C] <= carry;
      if (flag_mask[0])
        p_reg[`M6502_P_V] <= overflow;

      // CLC and SEC never come with a carry mask bit
      if (clc)
        p_reg[`M6502_P_C] <= 1'b0;
      if (sec)
        p_reg[`M6502_P_C] <= 1'b1;
    end
  end

  // Unused P bit must read as one whatever has been executed
  a_p_unused_set: assert property (@(posedge clk) disable iff (reset)
    p_reg[`M6502_P_U])
    else $error("P bit 5 cleared");

endmodule

`default_nettype wire

// ==== verif/m6502_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "m6502_defs.svh"

module m6502_exec_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_INSTR   = 200;
  localparam int ACK_LATENCY = 2;
  localparam int MAX_WAIT    = 10;

  logic                     clk;
  logic                     reset;
  logic                     req;
  logic [`M6502_DATA_W-1:0] opcode;
  logic [`M6502_DATA_W-1:0] operand;
  logic                     ack;
  logic [`M6502_DATA_W-1:0] a_reg;
  logic [`M6502_DATA_W-1:0] x_reg;
  logic [`M6502_DATA_W-1:0] y_reg;
  logic [`M6502_DATA_W-1:0] p_reg;

  // Expected architectural state
  logic [`M6502_DATA_W-1:0] exp_a;
  logic [`M6502_DATA_W-1:0] exp_x;
  logic [`M6502_DATA_W-1:0] exp_y;
  logic [`M6502_DATA_W-1:0] exp_p;
  logic [31:0]              lfsr;

  m6502_exec DUT (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .opcode  (opcode),
    .operand (operand),
    .ack     (ack),
    .a_reg   (a_reg),
    .x_reg   (x_reg),
    .y_reg   (y_reg),
    .p_reg   (p_reg)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  initial
  begin
    #(NUM_INSTR * 10 * CLK_PERIOD + 50 * CLK_PERIOD);
    abort_run("Watchdog expired before all tests completed");
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [`M6502_DATA_W-1:0] v);
    int k;
    for (k = 0; k < `M6502_DATA_W; k++)
    begin
      lfsr = lfsr_next(lfsr);
      v[k] = lfsr[0];
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
                          $time, what, got, exp));
  endtask

  task automatic check_byte(input string what, input logic [`M6502_DATA_W-1:0] got,
                            input logic [`M6502_DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t ns: %s is %02h, expected %02h",
                          $time, what, got, exp));
  endtask

  task automatic check_p(input logic [`M6502_DATA_W-1:0] got,
                         input logic [`M6502_DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t ns: P is %08b (NV-BDIZC), expected %08b",
                          $time, got, exp));
  endtask

  task automatic check_state();
    check_byte("A", a_reg, exp_a);
    check_byte("X", x_reg, exp_x);
    check_byte("Y", y_reg, exp_y);
    check_p(p_reg, exp_p);
  endtask

  // Reference behavior of each supported instruction on the expected state
  task automatic model_exec(input logic [7:0] op, input logic [7:0] m);
    logic [8:0] wide;
    logic [7:0] b;
    logic [7:0] r;
    logic       c;
    logic       nz;
    int         sres;
    c  = exp_p[`M6502_P_C];
    nz = 1'b1;
    r  = 8'h00;
    case (op)
      8'h09: r = exp_a | m;
      8'h29: r = exp_a & m;
      8'h49: r = exp_a ^ m;
      8'hA9: r = m;
      // SBC is ADC of the inverted operand
      8'h69, 8'hE9:
      begin
        b    = (op == 8'hE9) ? ~m : m;
        wide = {1'b0, exp_a} + {1'b0, b} + {8'h00, c};
        r    = wide[7:0];
        exp_p[`M6502_P_C] = wide[8];
        // Overflow when the signed result leaves -128..127
        if (op == 8'hE9)
          sres = int'($signed(exp_a)) - int'($signed(m)) - int'(!c);
        else
          sres = int'($signed(exp_a)) + int'($signed(m)) + int'(c);
        exp_p[`M6502_P_V] = (sres > 127) || (sres < -128);
      end
      8'hC9:
      begin
        r = exp_a - m;
        exp_p[`M6502_P_C] = (exp_a >= m);
      end
      8'h0A, 8'h2A:
      begin
        r = {exp_a[6:0], (op == 8'h2A) ? c : 1'b0};
        exp_p[`M6502_P_C] = exp_a[7];
      end
      8'h4A, 8'h6A:
      begin
        r = {(op == 8'h6A) ? c : 1'b0, exp_a[7:1]};
        exp_p[`M6502_P_C] = exp_a[0];
      end
      8'hE8: r = exp_x + 8'd1;
      8'hCA: r = exp_x - 8'd1;
      8'hC8: r = exp_y + 8'd1;
      8'h88: r = exp_y - 8'd1;
      8'hAA, 8'hA8: r = exp_a;
      8'h18: exp_p[`M6502_P_C] = 1'b0;
      8'h38: exp_p[`M6502_P_C] = 1'b1;
      default: nz = 1'b0;
    endcase
    if (op == 8'h18 || op == 8'h38 || op == 8'hC9)
      nz = nz && (op == 8'hC9);
    if (op inside {8'h09, 8'h29, 8'h49, 8'hA9, 8'h69, 8'hE9, 8'h0A, 8'h2A, 8'h4A, 8'h6A})
      exp_a = r;
    if (op inside {8'hE8, 8'hCA, 8'hAA})
      exp_x = r;
    if (op inside {8'hC8, 8'h88, 8'hA8})
      exp_y = r;
    if (nz)
    begin
      exp_p[`M6502_P_N] = r[7];
      exp_p[`M6502_P_Z] = (r == 8'h00);
    end
  endtask

  // Full four-phase handshake, req held for hold extra cycles after ack
  task automatic do_instr(input logic [7:0] op, input logic [7:0] m, input int hold);
    int edges;
    edges = 0;
    @(posedge clk);
    req     <= 1'b1;
    opcode  <= op;
    operand <= m;
    do
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!ack && edges < MAX_WAIT);
    if (!ack)
      abort_run($sformatf("No ack for opcode %02h within %0d cycles", op, MAX_WAIT));
    if (edges != ACK_LATENCY)
      abort_run($sformatf("ack for opcode %02h came after %0d edges, not %0d",
                          op, edges, ACK_LATENCY));
    repeat (hold)
    begin
      @(posedge clk);
      @(negedge clk);
      if (!ack)
        abort_run("ack dropped while req was still held high");
    end
    @(posedge clk);
    req   <= 1'b0;
    edges = 0;
    do
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (ack && edges < MAX_WAIT);
    if (ack)
      abort_run("ack stayed high after req was dropped");
    model_exec(op, m);
    check_state();
  endtask

  task automatic set_carry(input logic c);
    do_instr(c ? 8'h38 : 8'h18, 8'h00, 0);
  endtask

  task automatic test_reset();
    check_bit("ack", ack, 1'b0);
    check_state();
  endtask

  task automatic test_transfers();
    do_instr(8'hA9, 8'h00, 0);
    do_instr(8'hAA, 8'h00, 0);
    do_instr(8'hA9, 8'h80, 0);
    do_instr(8'hA8, 8'h00, 0);
    do_instr(8'hAA, 8'h00, 0);
    do_instr(8'hA9, 8'h7F, 0);
    do_instr(8'hA8, 8'h00, 0);
  endtask

  task automatic test_logic();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] op;
    int i;
    for (i = 0; i < 12; i++)
    begin
      rand_byte(a);
      rand_byte(b);
      op = (i % 3 == 0) ? 8'h29 : ((i % 3 == 1) ? 8'h09 : 8'h49);
      // 40 + 40 overflows into the sign bit, 40 + 00 does not
      do_instr(8'hA9, 8'h40, 0);
      do_instr(8'h69, (i % 2 == 0) ? 8'h40 : 8'h00, 0);
      set_carry(a[0] ^ b[7]);
      do_instr(8'hA9, a, 0);
      do_instr(op, b, 0);
    end
  endtask

  task automatic test_add_sub();
    logic [7:0] a;
    logic [7:0] b;
    int i;
    for (i = 0; i < 16; i++)
    begin
      rand_byte(a);
      rand_byte(b);
      lfsr = lfsr_next(lfsr);
      set_carry(lfsr[0]);
      do_instr(8'hA9, a, 0);
      do_instr((i % 2 == 0) ? 8'h69 : 8'hE9, b, 0);
    end
  endtask

  task automatic test_shifts();
    logic [7:0] a;
    int i;
    int k;
    for (i = 0; i < 4; i++)
    begin
      for (k = 0; k < 4; k++)
      begin
        rand_byte(a);
        do_instr(8'hA9, a, 0);
        lfsr = lfsr_next(lfsr);
        set_carry(lfsr[0]);
        do_instr(8'h0A + 8'(k * 32), 8'h00, 0);
      end
    end
    // Index register wrap in both directions
    do_instr(8'hA9, 8'hFF, 0);
    do_instr(8'hAA, 8'h00, 0);
    do_instr(8'hE8, 8'h00, 0);
    do_instr(8'hCA, 8'h00, 0);
    do_instr(8'hA9, 8'h00, 0);
    do_instr(8'hA8, 8'h00, 0);
    do_instr(8'h88, 8'h00, 0);
    do_instr(8'hC8, 8'h00, 0);
  endtask

  task automatic test_compare_misc();
    logic [7:0] a;
    logic [7:0] b;
    int i;
    for (i = 0; i < 8; i++)
    begin
      rand_byte(a);
      rand_byte(b);
      do_instr(8'hA9, a, 0);
      do_instr(8'hC9, (i == 0) ? a : b, 0);
    end
    // Unsupported opcode, acknowledged with no effect
    do_instr(8'h02, 8'h5A, 0);
    // Long req hold must not execute INX again
    do_instr(8'hE8, 8'h00, 6);
    do_instr(8'hC8, 8'h00, 3);
  endtask

  initial
  begin
    reset   = 1'b1;
    req     = 1'b0;
    opcode  = '0;
    operand = '0;
    lfsr    = 32'he873dded;
    exp_a   = '0;
    exp_x   = '0;
    exp_y   = '0;
    exp_p   = `M6502_P_RESET;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset();
    test_transfers();
    test_logic();
    test_add_sub();
    test_shifts();
    test_compare_misc();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
